// ==== run_sim.sh ====
#!/bin/sh
# Build and run the testbench with Verilator
set -e

cd "$(dirname "$0")"
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f sources.f --top-module hci_tb -o hci_sim

./obj_dir/hci_sim | tee sim.log

if grep -q "RESULT: FAIL" sim.log; then
  echo "Simulation failed, see sim.log"
  exit 1
fi

echo "Simulation finished without failure"

// ==== source/debug_ram.sv ====
module debug_ram (
  input  logic                           clk,
  input  logic                           i_we,
  input  logic [hci_pkg::HCI_MEM_AW-1:0] i_addr,
  input  logic [7:0]                     i_wdata,
  output logic [7:0]                     o_rdata
);

  logic [7:0] mem [2**hci_pkg::HCI_MEM_AW];

  // Registered read, old data on a write cycle
  always_ff @(posedge clk) begin
    if (i_we) begin
      mem[i_addr] <= i_wdata;
    end
    o_rdata <= mem[i_addr];
  end

endmodule

// ==== source/hci_bus_engine.sv ====
module hci_bus_engine (
  input  logic                           clk,
  input  logic                           i_arst_n,
  input  logic                           i_job_valid,
  output logic                           o_job_ready,
  input  hci_pkg::hci_job_t              i_job,
  output logic                           o_busy,
  input  logic                           i_wdata_valid,
  output logic                           o_wdata_ready,
  input  logic [7:0]                     i_wdata,
  output logic                           o_mem_we,
  output logic [hci_pkg::HCI_MEM_AW-1:0] o_mem_addr,
  output logic [7:0]                     o_mem_wdata,
  input  logic [7:0]                     i_mem_rdata,
  output logic                           o_rsp_valid,
  input  logic                           i_rsp_ready,
  output hci_pkg::hci_rsp_t              o_rsp
);

  typedef enum logic [2:0] {
    S_IDLE,
    S_RD_ADDR,
    S_RD_SEND,
    S_WR,
    S_STATUS
  } state_t;

  state_t                           state_q;
  logic [hci_pkg::HCI_MEM_AW-1:0]   addr_q;
  logic [15:0]                      count_q;
  logic [7:0]                       wdata_q;
  logic                             we_q;
  logic                             job_fire;
  logic                             rsp_fire;
  logic                             byte_fire;
  logic                             wr_fire;

  assign job_fire  = i_job_valid && o_job_ready;
  assign rsp_fire  = o_rsp_valid && i_rsp_ready;
  assign byte_fire = rsp_fire && (state_q == S_RD_SEND);
  assign wr_fire   = i_wdata_valid && o_wdata_ready;

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state_q <= S_IDLE;
      we_q    <= 1'b0;
    end else begin
      we_q <= wr_fire;
      case (state_q)
        S_IDLE: begin
          if (job_fire) begin
            if (i_job.count == 16'd0) begin
              state_q <= S_STATUS;
            end else begin
              state_q <= i_job.write ? S_WR : S_RD_ADDR;
            end
          end
        end
        // RAM samples addr_q here, byte shows up in S_RD_SEND
        S_RD_ADDR: state_q <= S_RD_SEND;
        S_RD_SEND: begin
          if (byte_fire) begin
            state_q <= (count_q == 16'd1) ? S_STATUS : S_RD_ADDR;
          end
        end
        S_WR: begin
          if (wr_fire && count_q == 16'd1) begin
            state_q <= S_STATUS;
          end
        end
        S_STATUS: begin
          if (rsp_fire) begin
            state_q <= S_IDLE;
          end
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  // Address wraps at the RAM size
  always_ff @(posedge clk) begin
    if (job_fire) begin
      addr_q  <= i_job.address[hci_pkg::HCI_MEM_AW-1:0];
      count_q <= i_job.count;
    end else begin
      if (byte_fire || we_q) begin
        addr_q <= addr_q + 1'b1;
      end
      if (byte_fire || wr_fire) begin
        count_q <= count_q - 16'd1;
      end
    end
    if (wr_fire) begin
      wdata_q <= i_wdata;
    end
  end

  assign o_job_ready   = (state_q == S_IDLE);
  assign o_busy        = (state_q != S_IDLE);
  assign o_wdata_ready = (state_q == S_WR);

  // Write lands one cycle after the byte is taken
  assign o_mem_we    = we_q;
  assign o_mem_addr  = addr_q;
  assign o_mem_wdata = wdata_q;

  // RAM output holds while addr_q is unchanged
  assign o_rsp_valid     = (state_q == S_RD_SEND) || (state_q == S_STATUS);
  assign o_rsp.is_status = (state_q == S_STATUS);
  assign o_rsp.data      = i_mem_rdata;
  assign o_rsp.status    = (state_q == S_STATUS) ? hci_pkg::HCI_OS_OK : '0;

  a_no_job_when_busy: assert property (@(posedge clk) disable iff (!i_arst_n)
    o_busy |-> !i_job_valid);

endmodule

// ==== source/hci_decoder.sv ====
module hci_decoder (
  input  logic              clk,
  input  logic              i_arst_n,
  input  logic              i_cpu_break,
  input  logic              i_cmd_valid,
  output logic              o_cmd_ready,
  input  hci_pkg::hci_cmd_t i_cmd,
  output logic              o_cpu_job_valid,
  input  logic              i_cpu_job_ready,
  output logic              o_ppu_job_valid,
  input  logic              i_ppu_job_ready,
  output hci_pkg::hci_job_t o_job,
  input  logic              i_cpu_busy,
  input  logic              i_ppu_busy,
  output logic              o_rsp_valid,
  input  logic              i_rsp_ready,
  output hci_pkg::hci_rsp_t o_rsp,
  output logic              o_dbg_active
);

  logic                             dbg_q;
  logic                             rsp_valid_q;
  logic [hci_pkg::HCI_STATUS_W-1:0] status_q;
  logic                             job_valid_q;
  logic                             job_cpu_q;
  hci_pkg::hci_job_t                job_q;
  logic                             cmd_fire;
  logic                             job_fire;
  logic                             is_cpu_op;
  logic                             is_ppu_op;
  logic                             dispatch;
  logic                             dbg_nxt;
  logic [hci_pkg::HCI_STATUS_W-1:0] status_nxt;

  // One command in flight, engines included
  assign o_cmd_ready = !rsp_valid_q && !job_valid_q && !i_cpu_busy && !i_ppu_busy;
  assign cmd_fire    = i_cmd_valid && o_cmd_ready;
  assign job_fire    = (o_cpu_job_valid && i_cpu_job_ready) ||
                       (o_ppu_job_valid && i_ppu_job_ready);

  assign is_cpu_op = (i_cmd.opcode == hci_pkg::HCI_OP_CPU_MEM_RD) ||
                     (i_cmd.opcode == hci_pkg::HCI_OP_CPU_MEM_WR);
  assign is_ppu_op = (i_cmd.opcode == hci_pkg::HCI_OP_PPU_MEM_RD) ||
                     (i_cmd.opcode == hci_pkg::HCI_OP_PPU_MEM_WR);

  always_comb begin
    dispatch   = 1'b0;
    dbg_nxt    = dbg_q;
    status_nxt = hci_pkg::HCI_OS_OK;
    if (!dbg_q) begin
      // Running: only NOP, BRK and QUERY are known
      case (i_cmd.opcode)
        hci_pkg::HCI_OP_NOP: ;
        hci_pkg::HCI_OP_DBG_BRK: dbg_nxt = 1'b1;
        hci_pkg::HCI_OP_QUERY_BRK: status_nxt = hci_pkg::HCI_OS_ERROR;
        default: begin
          if (is_cpu_op || is_ppu_op) begin
            status_nxt = hci_pkg::HCI_OS_ERROR;
          end else begin
            status_nxt = hci_pkg::HCI_OS_UNKNOWN | hci_pkg::HCI_OS_ERROR;
          end
        end
      endcase
    end else begin
      case (i_cmd.opcode)
        hci_pkg::HCI_OP_NOP, hci_pkg::HCI_OP_DBG_BRK, hci_pkg::HCI_OP_QUERY_BRK: ;
        hci_pkg::HCI_OP_DBG_RUN: dbg_nxt = 1'b0;
        default: begin
          if (!(is_cpu_op || is_ppu_op)) begin
            status_nxt = hci_pkg::HCI_OS_UNKNOWN | hci_pkg::HCI_OS_ERROR;
          end else if (i_cmd.count == 16'd0) begin
            status_nxt = hci_pkg::HCI_OS_COUNT_ZERO | hci_pkg::HCI_OS_ERROR;
          end else begin
            dispatch = 1'b1;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      dbg_q       <= 1'b0;
      rsp_valid_q <= 1'b0;
      job_valid_q <= 1'b0;
      job_cpu_q   <= 1'b0;
    end else if (cmd_fire) begin
      dbg_q       <= dbg_nxt;
      rsp_valid_q <= !dispatch;
      job_valid_q <= dispatch;
      job_cpu_q   <= is_cpu_op;
    end else begin
      // Core-side break only matters while running
      if (!dbg_q && i_cpu_break) begin
        dbg_q <= 1'b1;
      end
      if (rsp_valid_q && i_rsp_ready) begin
        rsp_valid_q <= 1'b0;
      end
      if (job_fire) begin
        job_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (cmd_fire) begin
      status_q      <= status_nxt;
      job_q.write   <= (i_cmd.opcode == hci_pkg::HCI_OP_CPU_MEM_WR) ||
                       (i_cmd.opcode == hci_pkg::HCI_OP_PPU_MEM_WR);
      job_q.address <= i_cmd.address;
      job_q.count   <= i_cmd.count;
    end
  end

  assign o_cpu_job_valid = job_valid_q && job_cpu_q;
  assign o_ppu_job_valid = job_valid_q && !job_cpu_q;
  assign o_job           = job_q;
  assign o_rsp_valid     = rsp_valid_q;
  assign o_rsp           = '{is_status: 1'b1, data: 8'h00, status: status_q};
  assign o_dbg_active    = dbg_q;

  a_one_job: assert property (@(posedge clk) disable iff (!i_arst_n)
    !(o_cpu_job_valid && o_ppu_job_valid));

endmodule

// ==== source/hci_pkg.sv ====
package hci_pkg;

  // Host command opcodes
  localparam logic [7:0] HCI_OP_NOP        = 8'h00;
  localparam logic [7:0] HCI_OP_DBG_BRK    = 8'h01;
  localparam logic [7:0] HCI_OP_DBG_RUN    = 8'h02;
  localparam logic [7:0] HCI_OP_QUERY_BRK  = 8'h03;
  localparam logic [7:0] HCI_OP_CPU_MEM_RD = 8'h04;
  localparam logic [7:0] HCI_OP_CPU_MEM_WR = 8'h05;
  localparam logic [7:0] HCI_OP_PPU_MEM_RD = 8'h08;
  localparam logic [7:0] HCI_OP_PPU_MEM_WR = 8'h09;

  localparam int HCI_STATUS_W = 4;
  localparam int HCI_MEM_AW   = 10;

  // One-hot status bits, OR-ed together in a status item
  localparam logic [HCI_STATUS_W-1:0] HCI_OS_OK         = 4'h1;
  localparam logic [HCI_STATUS_W-1:0] HCI_OS_ERROR      = 4'h2;
  localparam logic [HCI_STATUS_W-1:0] HCI_OS_UNKNOWN    = 4'h4;
  localparam logic [HCI_STATUS_W-1:0] HCI_OS_COUNT_ZERO = 4'h8;

  typedef struct packed {
    logic [7:0]  opcode;
    logic [15:0] address;
    logic [15:0] count;
  } hci_cmd_t;

  // Transfer job for one bus engine
  typedef struct packed {
    logic        write;
    logic [15:0] address;
    logic [15:0] count;
  } hci_job_t;

  // Data item carries a byte, status item closes the response
  typedef struct packed {
    logic                    is_status;
    logic [7:0]              data;
    logic [HCI_STATUS_W-1:0] status;
  } hci_rsp_t;

endpackage

// ==== source/hci_response_merge.sv ====
module hci_response_merge (
  input  logic              clk,
  input  logic              i_arst_n,
  input  logic              i_dec_valid,
  output logic              o_dec_ready,
  input  hci_pkg::hci_rsp_t i_dec_rsp,
  input  logic              i_cpu_valid,
  output logic              o_cpu_ready,
  input  hci_pkg::hci_rsp_t i_cpu_rsp,
  input  logic              i_ppu_valid,
  output logic              o_ppu_ready,
  input  hci_pkg::hci_rsp_t i_ppu_rsp,
  output logic              o_rsp_valid,
  input  logic              i_rsp_ready,
  output hci_pkg::hci_rsp_t o_rsp
);

  logic [2:0]        src_valid;
  hci_pkg::hci_rsp_t src_rsp [3];
  logic [1:0]        pri_sel;
  logic [1:0]        cur_sel;
  logic [1:0]        grant_q;
  logic              locked_q;
  logic              last_fire;

  assign src_valid  = {i_ppu_valid, i_cpu_valid, i_dec_valid};
  assign src_rsp[0] = i_dec_rsp;
  assign src_rsp[1] = i_cpu_rsp;
  assign src_rsp[2] = i_ppu_rsp;

  // Fixed priority: decoder, CPU, PPU
  always_comb begin
    if (i_dec_valid) begin
      pri_sel = 2'd0;
    end else if (i_cpu_valid) begin
      pri_sel = 2'd1;
    end else begin
      pri_sel = 2'd2;
    end
  end

  assign cur_sel     = locked_q ? grant_q : pri_sel;
  assign o_rsp_valid = src_valid[cur_sel];
  assign o_rsp       = src_rsp[cur_sel];
  assign o_dec_ready = i_rsp_ready && (cur_sel == 2'd0);
  assign o_cpu_ready = i_rsp_ready && (cur_sel == 2'd1);
  assign o_ppu_ready = i_rsp_ready && (cur_sel == 2'd2);
  assign last_fire   = o_rsp_valid && i_rsp_ready && o_rsp.is_status;

  // Lock as soon as an item is offered, release after its status
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      locked_q <= 1'b0;
      grant_q  <= 2'd0;
    end else if (last_fire) begin
      locked_q <= 1'b0;
    end else if (o_rsp_valid) begin
      locked_q <= 1'b1;
      grant_q  <= cur_sel;
    end
  end

  a_grant_held: assert property (@(posedge clk) disable iff (!i_arst_n)
    o_rsp_valid && !last_fire |=> cur_sel == $past(cur_sel));

endmodule

// ==== source/hci_stream_slice.sv ====
module hci_stream_slice #(
  parameter type T = logic [7:0]
) (
  input  logic clk,
  input  logic i_arst_n,
  input  logic i_valid,
  output logic o_ready,
  input  T     i_data,
  output logic o_valid,
  input  logic i_ready,
  output T     o_data
);

  T     skid_q;
  logic skid_valid_q;
  logic skid_nxt;
  logic in_fire;
  logic out_load;

  assign in_fire  = i_valid && o_ready;
  // Output register may take a new item when empty or when drained
  assign out_load = !o_valid || i_ready;
  assign skid_nxt = out_load ? 1'b0 : (skid_valid_q || in_fire);

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_valid      <= 1'b0;
      o_ready      <= 1'b0;
      skid_valid_q <= 1'b0;
    end else begin
      skid_valid_q <= skid_nxt;
      o_ready      <= !skid_nxt;
      if (out_load) begin
        o_valid <= skid_valid_q || in_fire;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (out_load) begin
      o_data <= skid_valid_q ? skid_q : i_data;
    end
    // Park the item that arrived while the output was stalled
    if (in_fire && !out_load) begin
      skid_q <= i_data;
    end
  end

  a_hold_stable: assert property (@(posedge clk) disable iff (!i_arst_n)
    o_valid && !i_ready |=> o_valid && $stable(o_data));

endmodule

// ==== source/hci_top.sv ====
module hci_top (
  input  logic              clk,
  input  logic              i_arst_n,
  input  logic              i_cmd_valid,
  output logic              o_cmd_ready,
  input  hci_pkg::hci_cmd_t i_cmd,
  input  logic              i_wdata_valid,
  output logic              o_wdata_ready,
  input  logic [7:0]        i_wdata,
  output logic              o_rsp_valid,
  input  logic              i_rsp_ready,
  output hci_pkg::hci_rsp_t o_rsp,
  input  logic              i_cpu_break,
  output logic              o_dbg_active
);

  logic                           cmd_valid;
  logic                           cmd_ready;
  hci_pkg::hci_cmd_t              cmd;
  logic                           cpu_job_valid;
  logic                           cpu_job_ready;
  logic                           ppu_job_valid;
  logic                           ppu_job_ready;
  hci_pkg::hci_job_t              job;
  logic                           cpu_busy;
  logic                           ppu_busy;
  logic                           dec_rsp_valid;
  logic                           dec_rsp_ready;
  hci_pkg::hci_rsp_t              dec_rsp;
  logic                           cpu_rsp_valid;
  logic                           cpu_rsp_ready;
  hci_pkg::hci_rsp_t              cpu_rsp;
  logic                           ppu_rsp_valid;
  logic                           ppu_rsp_ready;
  hci_pkg::hci_rsp_t              ppu_rsp;
  logic                           mrg_valid;
  logic                           mrg_ready;
  hci_pkg::hci_rsp_t              mrg_rsp;
  logic                           cpu_wready;
  logic                           ppu_wready;
  logic                           cpu_we;
  logic [hci_pkg::HCI_MEM_AW-1:0] cpu_addr;
  logic [7:0]                     cpu_wdata;
  logic [7:0]                     cpu_rdata;
  logic                           ppu_we;
  logic [hci_pkg::HCI_MEM_AW-1:0] ppu_addr;
  logic [7:0]                     ppu_wdata;
  logic [7:0]                     ppu_rdata;

  // Only the engine running a write raises its ready
  assign o_wdata_ready = cpu_wready | ppu_wready;

  hci_stream_slice #(.T(hci_pkg::hci_cmd_t)) u_cmd_slice (
    .clk(clk), .i_arst_n(i_arst_n),
    .i_valid(i_cmd_valid), .o_ready(o_cmd_ready), .i_data(i_cmd),
    .o_valid(cmd_valid), .i_ready(cmd_ready), .o_data(cmd)
  );

  hci_decoder u_decoder (
    .clk(clk), .i_arst_n(i_arst_n), .i_cpu_break(i_cpu_break),
    .i_cmd_valid(cmd_valid), .o_cmd_ready(cmd_ready), .i_cmd(cmd),
    .o_cpu_job_valid(cpu_job_valid), .i_cpu_job_ready(cpu_job_ready),
    .o_ppu_job_valid(ppu_job_valid), .i_ppu_job_ready(ppu_job_ready),
    .o_job(job), .i_cpu_busy(cpu_busy), .i_ppu_busy(ppu_busy),
    .o_rsp_valid(dec_rsp_valid), .i_rsp_ready(dec_rsp_ready), .o_rsp(dec_rsp),
    .o_dbg_active(o_dbg_active)
  );

  hci_bus_engine u_cpu_engine (
    .clk(clk), .i_arst_n(i_arst_n),
    .i_job_valid(cpu_job_valid), .o_job_ready(cpu_job_ready), .i_job(job),
    .o_busy(cpu_busy),
    .i_wdata_valid(i_wdata_valid), .o_wdata_ready(cpu_wready), .i_wdata(i_wdata),
    .o_mem_we(cpu_we), .o_mem_addr(cpu_addr), .o_mem_wdata(cpu_wdata),
    .i_mem_rdata(cpu_rdata),
    .o_rsp_valid(cpu_rsp_valid), .i_rsp_ready(cpu_rsp_ready), .o_rsp(cpu_rsp)
  );

  hci_bus_engine u_ppu_engine (
    .clk(clk), .i_arst_n(i_arst_n),
    .i_job_valid(ppu_job_valid), .o_job_ready(ppu_job_ready), .i_job(job),
    .o_busy(ppu_busy),
    .i_wdata_valid(i_wdata_valid), .o_wdata_ready(ppu_wready), .i_wdata(i_wdata),
    .o_mem_we(ppu_we), .o_mem_addr(ppu_addr), .o_mem_wdata(ppu_wdata),
    .i_mem_rdata(ppu_rdata),
    .o_rsp_valid(ppu_rsp_valid), .i_rsp_ready(ppu_rsp_ready), .o_rsp(ppu_rsp)
  );

  hci_response_merge u_merge (
    .clk(clk), .i_arst_n(i_arst_n),
    .i_dec_valid(dec_rsp_valid), .o_dec_ready(dec_rsp_ready), .i_dec_rsp(dec_rsp),
    .i_cpu_valid(cpu_rsp_valid), .o_cpu_ready(cpu_rsp_ready), .i_cpu_rsp(cpu_rsp),
    .i_ppu_valid(ppu_rsp_valid), .o_ppu_ready(ppu_rsp_ready), .i_ppu_rsp(ppu_rsp),
    .o_rsp_valid(mrg_valid), .i_rsp_ready(mrg_ready), .o_rsp(mrg_rsp)
  );

  hci_stream_slice #(.T(hci_pkg::hci_rsp_t)) u_rsp_slice (
    .clk(clk), .i_arst_n(i_arst_n),
    .i_valid(mrg_valid), .o_ready(mrg_ready), .i_data(mrg_rsp),
    .o_valid(o_rsp_valid), .i_ready(i_rsp_ready), .o_data(o_rsp)
  );

  // Stand-ins for CPU memory and VRAM
  debug_ram u_cpu_ram (
    .clk(clk), .i_we(cpu_we), .i_addr(cpu_addr), .i_wdata(cpu_wdata), .o_rdata(cpu_rdata)
  );

  debug_ram u_ppu_ram (
    .clk(clk), .i_we(ppu_we), .i_addr(ppu_addr), .i_wdata(ppu_wdata), .o_rdata(ppu_rdata)
  );

endmodule

// ==== sources.f ====
source/hci_pkg.sv
source/hci_stream_slice.sv
source/hci_decoder.sv
source/hci_bus_engine.sv
source/hci_response_merge.sv
source/debug_ram.sv
source/hci_top.sv
verification/hci_clock_gen.sv
verification/hci_tb.sv

// ==== verification/hci_clock_gen.sv ====
module hci_clock_gen (
  output logic clk
);

  // Period of 40 time units
  initial begin
    clk = 1'b0;
    forever begin
      #20 clk = ~clk;
    end
  end

endmodule

// ==== verification/hci_tb.sv ====
module hci_tb;

  // About 40 commands of at most ~100 cycles each under back-pressure, with wide margin
  localparam int TIMEOUT_CYCLES = 20000;

  typedef struct packed {
    logic [hci_pkg::HCI_STATUS_W-1:0] status;
    logic [15:0]                      n_data;
    logic                             next_brk;
  } ref_result_t;

  logic              clk;
  logic              i_arst_n;
  logic              i_cmd_valid;
  logic              o_cmd_ready;
  hci_pkg::hci_cmd_t i_cmd;
  logic              i_wdata_valid;
  logic              o_wdata_ready;
  logic [7:0]        i_wdata;
  logic              o_rsp_valid;
  logic              i_rsp_ready;
  hci_pkg::hci_rsp_t o_rsp;
  logic              i_cpu_break;
  logic              o_dbg_active;

  // Shadow copies of CPU memory and VRAM
  logic [7:0]        cpu_shadow [1024];
  logic [7:0]        ppu_shadow [1024];
  logic [31:0]       rnd_pool [4096];
  integer            seed;
  int                pool_idx = 0;
  int                cycles = 0;
  int                error_count = 0;
  logic              tb_brk;
  string             cur_test;
  hci_pkg::hci_rsp_t exp_q [$];
  hci_pkg::hci_rsp_t exp_item;
  logic [31:0]       rnd_word;
  logic [15:0]       xfer_addr [5];
  logic [15:0]       xfer_count [5];
  int                k;

  hci_clock_gen u_clk_gen (
    .clk(clk)
  );

  hci_top DUT (
    .clk(clk), .i_arst_n(i_arst_n),
    .i_cmd_valid(i_cmd_valid), .o_cmd_ready(o_cmd_ready), .i_cmd(i_cmd),
    .i_wdata_valid(i_wdata_valid), .o_wdata_ready(o_wdata_ready), .i_wdata(i_wdata),
    .o_rsp_valid(o_rsp_valid), .i_rsp_ready(i_rsp_ready), .o_rsp(o_rsp),
    .i_cpu_break(i_cpu_break), .o_dbg_active(o_dbg_active)
  );

  task automatic stop_with_failure(input string reason);
    error_count++;
    $display("%s", reason);
    $display("RESULT: FAIL");
    $fatal(1, "Simulation stopped on the first error");
  endtask

  task automatic check_value(input string what, input logic [15:0] expected,
                             input logic [15:0] actual);
    assert (expected === actual) else begin
      stop_with_failure($sformatf("FAILED %s %s: expected 0x%0h, actual 0x%0h",
                                  cur_test, what, expected, actual));
    end
  endtask

  function automatic logic [31:0] draw_random();
    logic [31:0] value;
    value    = rnd_pool[2048 + pool_idx];
    pool_idx = (pool_idx + 1) % 2048;
    return value;
  endfunction

  // Expected status, data item count and next break state of one command
  function automatic ref_result_t predict_response(input logic [7:0] op, input logic brk,
                                                   input logic [15:0] count);
    ref_result_t r;
    logic        is_read;
    logic        is_xfer;
    is_read    = (op == hci_pkg::HCI_OP_CPU_MEM_RD) || (op == hci_pkg::HCI_OP_PPU_MEM_RD);
    is_xfer    = is_read || (op == hci_pkg::HCI_OP_CPU_MEM_WR) ||
                 (op == hci_pkg::HCI_OP_PPU_MEM_WR);
    r.status   = hci_pkg::HCI_OS_OK;
    r.n_data   = 16'd0;
    r.next_brk = brk;
    if (!brk) begin
      // Running: only NOP and BRK succeed
      if (op == hci_pkg::HCI_OP_DBG_BRK) begin
        r.next_brk = 1'b1;
      end else if (op == hci_pkg::HCI_OP_QUERY_BRK || is_xfer) begin
        r.status = hci_pkg::HCI_OS_ERROR;
      end else if (op != hci_pkg::HCI_OP_NOP) begin
        r.status = hci_pkg::HCI_OS_UNKNOWN | hci_pkg::HCI_OS_ERROR;
      end
    end else begin
      if (op == hci_pkg::HCI_OP_DBG_RUN) begin
        r.next_brk = 1'b0;
      end else if (is_xfer && count == 16'd0) begin
        r.status = hci_pkg::HCI_OS_COUNT_ZERO | hci_pkg::HCI_OS_ERROR;
      end else if (is_xfer) begin
        if (is_read) begin
          r.n_data = count;
        end
      end else if (op != hci_pkg::HCI_OP_NOP && op != hci_pkg::HCI_OP_DBG_BRK &&
                   op != hci_pkg::HCI_OP_QUERY_BRK) begin
        r.status = hci_pkg::HCI_OS_UNKNOWN | hci_pkg::HCI_OS_ERROR;
      end
    end
    return r;
  endfunction

  task automatic run_command(input string name, input logic [7:0] op,
                             input logic [15:0] addr, input logic [15:0] count);
    ref_result_t                    r;
    logic                           is_cpu;
    logic                           is_write;
    logic [hci_pkg::HCI_MEM_AW-1:0] a;
    logic [7:0]                     b;
    logic [31:0]                    rnd;
    int                             i;
    cur_test = name;
    r        = predict_response(op, tb_brk, count);
    is_cpu   = (op == hci_pkg::HCI_OP_CPU_MEM_RD) || (op == hci_pkg::HCI_OP_CPU_MEM_WR);
    is_write = (op == hci_pkg::HCI_OP_CPU_MEM_WR) || (op == hci_pkg::HCI_OP_PPU_MEM_WR);
    // Queue the expected items before the command goes out
    a = addr[hci_pkg::HCI_MEM_AW-1:0];
    for (i = 0; i < int'(r.n_data); i++) begin
      exp_q.push_back('{is_status: 1'b0, data: is_cpu ? cpu_shadow[a] : ppu_shadow[a],
                        status: '0});
      a = a + 10'd1;
    end
    exp_q.push_back('{is_status: 1'b1, data: 8'h00, status: r.status});
    @(negedge clk);
    i_cmd_valid = 1'b1;
    i_cmd       = '{opcode: op, address: addr, count: count};
    do @(posedge clk); while (!o_cmd_ready);
    @(negedge clk);
    i_cmd_valid = 1'b0;
    if (is_write && r.status == hci_pkg::HCI_OS_OK) begin
      a = addr[hci_pkg::HCI_MEM_AW-1:0];
      for (i = 0; i < int'(count); i++) begin
        rnd = draw_random();
        // Occasional idle cycle between bytes
        if (rnd[9:8] == 2'b00) begin
          @(negedge clk);
        end
        b             = rnd[7:0];
        i_wdata_valid = 1'b1;
        i_wdata       = b;
        do @(posedge clk); while (!o_wdata_ready);
        if (is_cpu) begin
          cpu_shadow[a] = b;
        end else begin
          ppu_shadow[a] = b;
        end
        a = a + 10'd1;
        @(negedge clk);
        i_wdata_valid = 1'b0;
      end
    end
    while (exp_q.size() != 0) begin
      @(negedge clk);
    end
    tb_brk = r.next_brk;
    check_value("dbg_active", 16'(tb_brk), 16'(o_dbg_active));
  endtask

  // Response checker
  always @(posedge clk) begin
    if (i_arst_n && o_rsp_valid && i_rsp_ready) begin
      if (exp_q.size() == 0) begin
        stop_with_failure("Error: a response item arrived while no response was expected");
      end else begin
        exp_item = exp_q.pop_front();
        check_value("is_status", 16'(exp_item.is_status), 16'(o_rsp.is_status));
        if (exp_item.is_status) begin
          check_value("status", 16'(exp_item.status), 16'(o_rsp.status));
        end else begin
          check_value("data", 16'(exp_item.data), 16'(o_rsp.data));
        end
      end
    end
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      stop_with_failure($sformatf("Timeout: the run did not finish within %0d cycles",
                                  TIMEOUT_CYCLES));
    end
  end

  // Random back-pressure on the response stream, about one cycle in four
  initial begin
    i_rsp_ready = 1'b0;
    forever begin
      @(negedge clk);
      i_rsp_ready = i_arst_n && (rnd_pool[cycles % 2048][1:0] != 2'b00);
    end
  end

  initial begin
    seed          = 32'h5c6d;
    tb_brk        = 1'b0;
    cur_test      = "reset";
    i_arst_n      = 1'b0;
    i_cmd_valid   = 1'b0;
    i_cmd         = '0;
    i_wdata_valid = 1'b0;
    i_wdata       = 8'h00;
    i_cpu_break   = 1'b0;
    for (k = 0; k < 4096; k++) begin
      rnd_pool[k] = $random(seed);
    end
    repeat (5) @(posedge clk);
    @(negedge clk);
    check_value("cmd_ready", 16'd0, 16'(o_cmd_ready));
    check_value("wdata_ready", 16'd0, 16'(o_wdata_ready));
    check_value("rsp_valid", 16'd0, 16'(o_rsp_valid));
    check_value("dbg_active", 16'd0, 16'(o_dbg_active));
    i_arst_n = 1'b1;

    // Running state
    run_command("run_nop", hci_pkg::HCI_OP_NOP, 16'h0000, 16'd0);
    run_command("run_query", hci_pkg::HCI_OP_QUERY_BRK, 16'h0000, 16'd0);
    run_command("run_cpu_rd", hci_pkg::HCI_OP_CPU_MEM_RD, 16'h0010, 16'd4);
    run_command("run_unknown", 8'h7F, 16'h0000, 16'd0);

    // Break entry by command and by the core
    run_command("brk", hci_pkg::HCI_OP_DBG_BRK, 16'h0000, 16'd0);
    run_command("brk_query", hci_pkg::HCI_OP_QUERY_BRK, 16'h0000, 16'd0);
    run_command("brk_run", hci_pkg::HCI_OP_DBG_RUN, 16'h0000, 16'd0);
    cur_test = "cpu_break_pulse";
    @(negedge clk);
    i_cpu_break = 1'b1;
    @(negedge clk);
    i_cpu_break = 1'b0;
    @(negedge clk);
    tb_brk = 1'b1;
    check_value("dbg_active", 16'd1, 16'(o_dbg_active));

    // Last range wraps from 1016 past 1023, upper address bits ignored
    for (k = 0; k < 4; k++) begin
      rnd_word      = draw_random();
      xfer_addr[k]  = rnd_word[15:0];
      xfer_count[k] = 16'(rnd_word[31:16] % 16'd20) + 16'd1;
    end
    xfer_addr[4]  = 16'hFBF8;
    xfer_count[4] = 16'd20;

    for (k = 0; k < 5; k++) begin
      run_command($sformatf("cpu_wr_%0d", k), hci_pkg::HCI_OP_CPU_MEM_WR,
                  xfer_addr[k], xfer_count[k]);
      run_command($sformatf("cpu_rd_%0d", k), hci_pkg::HCI_OP_CPU_MEM_RD,
                  xfer_addr[k], xfer_count[k]);
    end

    // Same ranges on VRAM, then CPU memory must be untouched
    for (k = 0; k < 5; k++) begin
      run_command($sformatf("ppu_wr_%0d", k), hci_pkg::HCI_OP_PPU_MEM_WR,
                  xfer_addr[k], xfer_count[k]);
      run_command($sformatf("ppu_rd_%0d", k), hci_pkg::HCI_OP_PPU_MEM_RD,
                  xfer_addr[k], xfer_count[k]);
    end
    for (k = 0; k < 5; k++) begin
      run_command($sformatf("cpu_recheck_%0d", k), hci_pkg::HCI_OP_CPU_MEM_RD,
                  xfer_addr[k], xfer_count[k]);
    end

    run_command("cpu_rd_count0", hci_pkg::HCI_OP_CPU_MEM_RD, 16'h0020, 16'd0);
    run_command("ppu_wr_count0", hci_pkg::HCI_OP_PPU_MEM_WR, 16'h0020, 16'd0);

    // Back to running, transfers refused
    run_command("final_run", hci_pkg::HCI_OP_DBG_RUN, 16'h0000, 16'd0);
    run_command("run_cpu_wr", hci_pkg::HCI_OP_CPU_MEM_WR, 16'h0040, 16'd3);
    run_command("run_ppu_rd", hci_pkg::HCI_OP_PPU_MEM_RD, 16'h0040, 16'd3);
    check_value("wdata_ready", 16'd0, 16'(o_wdata_ready));

    repeat (4) @(negedge clk);
    if (error_count == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule
